// File: Makefile
VERILATOR ?= verilator
TOP := tb_fpga_top
FILELIST := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS := --binary --timing --assert -j 0
OBJ_DIR := obj_dir
LOG := sim.log
FAIL_MSG := ERRORS FOUND
PASS_MSG := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/fpga_top_assertions.sv
/*
 * concurrent checks on the monitor top level
 * control strobes, transmit back-pressure and idle serial line in reset
 */

`timescale 1ns/1ns
`default_nettype none

module fpga_top_assertions (
	input logic clk,
	input logic i_arst_n,
	input logic i_tx,
	input logic i_cpu_start,
	input logic i_quit_cmd,
	input logic i_tx_send,
	input logic i_tx_busy
);

	// cpu control strobes last one cycle
	a_start_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_cpu_start |=> !i_cpu_start)
		else $error("cpu start strobe held for two cycles");

	a_quit_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_quit_cmd |=> !i_quit_cmd)
		else $error("quit strobe held for two cycles");

	// monitor waits for the transmitter
	a_send_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_tx_send |-> !i_tx_busy)
		else $error("send strobe while transmitter busy");

	// idle line during reset
	a_tx_reset: assert property (@(posedge clk)
		!i_arst_n |-> i_tx)
		else $error("serial line low during reset");

endmodule

bind fpga_top fpga_top_assertions u_assertions (
	.clk(clk),
	.i_arst_n(i_arst_n),
	.i_tx(o_tx),
	.i_cpu_start(o_cpu_start),
	.i_quit_cmd(o_quit_cmd),
	.i_tx_send(tx_send),
	.i_tx_busy(tx_busy)
);

`default_nettype wire

// File: dv/tb_fpga_top.sv
/*
 * testbench for the debug monitor top level
 * plays the UART host and the CPU core, applies a table of host commands
 * and CPU stores, decodes replies on o_tx and counts the control pulses
 */

`timescale 1ns/1ns
`default_nettype none

module tb_fpga_top
	import rvmon_pkg::*;
();

	localparam int NUM_ENTRIES = 19;
	// generous bound on clocks for a four byte reply
	localparam int REPLY_LIMIT = 6 * 10 * CLKS_PER_BIT;
	localparam int WATCHDOG_NS = NUM_ENTRIES * 12 * 10 * CLKS_PER_BIT * 10 * 2;

	// one table row for a host command or a CPU store
	typedef struct packed {
		logic is_store;
		byte_t cmd;
		word_t adr;
		word_t data;
		be_t be;
		word_t exp;
	} entry_t;

	logic clk;
	logic i_arst_n;
	logic i_rx;
	logic o_tx;
	logic [2:0] o_rgb_led;
	logic o_cpu_start;
	start_adr_t o_start_adr;
	logic o_quit_cmd;
	word_t i_pc_data;
	io_store_t i_st_io;

	entry_t tbl [NUM_ENTRIES];
	int n_entries = 0;
	integer seed;
	byte_t rx_q [$];
	int start_cnt = 0;
	int quit_cnt = 0;
	int passed = 0;
	int failed = 0;
	int line_errs = 0;

	fpga_top DUT (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_rx(i_rx),
		.o_tx(o_tx),
		.o_rgb_led(o_rgb_led),
		.o_cpu_start(o_cpu_start),
		.o_start_adr(o_start_adr),
		.o_quit_cmd(o_quit_cmd),
		.i_pc_data(i_pc_data),
		.i_st_io(i_st_io)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// host side receiver samples mid-bit on the falling clock edge
	initial begin : tx_decode
		byte_t b;
		forever begin
			@(negedge o_tx);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			if (o_tx == 1'b0) begin
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					b[i] = o_tx;
				end
				// stop bit
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (o_tx == 1'b1) begin
					rx_q.push_back(b);
				end else begin
					$display("reply byte at %0t has no stop bit", $time);
					line_errs++;
				end
			end
		end
	end

	// count the single cycle strobes on the falling edge
	always @(negedge clk) begin
		if (o_cpu_start) start_cnt++;
		if (o_quit_cmd) quit_cnt++;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic add_entry(input logic is_store, input byte_t cmd, input word_t adr,
			input word_t data, input be_t be, input word_t exp);
		tbl[n_entries] = '{is_store, cmd, adr, data, be, exp};
		n_entries++;
	endtask

	task automatic build_table();
		word_t d0;
		word_t d1;
		word_t d2;
		word_t d3;
		word_t d4;
		word_t pc;
		d0 = $random(seed);
		d1 = $random(seed);
		d2 = $random(seed);
		d3 = $random(seed);
		d4 = $random(seed);
		pc = $random(seed);
		// unknown byte first straight after reset
		add_entry(1'b0, 8'h7a, '0, '0, '0, '0);
		// instruction and data words at shared addresses
		add_entry(1'b0, CMD_IWR, 32'h000, d0, '0, '0);
		add_entry(1'b0, CMD_IWR, 32'h3ff, d1, '0, '0);
		add_entry(1'b0, CMD_IWR, 32'h155, d2, '0, '0);
		add_entry(1'b0, CMD_DWR, 32'h155, d3, '0, '0);
		add_entry(1'b0, CMD_DWR, 32'h3ff, d4, '0, '0);
		add_entry(1'b0, CMD_IRD, 32'h000, '0, '0, d0);
		add_entry(1'b0, CMD_IRD, 32'h3ff, '0, '0, d1);
		add_entry(1'b0, CMD_IRD, 32'h155, '0, '0, d2);
		// high address bits dropped so this reads the word at 0x155
		add_entry(1'b0, CMD_IRD, 32'hfd55, '0, '0, d2);
		add_entry(1'b0, CMD_DRD, 32'h155, '0, '0, d3);
		add_entry(1'b0, CMD_DRD, 32'h3ff, '0, '0, d4);
		// go takes byte address bits 31..2
		add_entry(1'b0, CMD_GO, 32'h8000_1236, '0, '0, {2'b00, 30'(32'h8000_1236 >> 2)});
		add_entry(1'b0, CMD_QUIT, '0, '0, '0, '0);
		add_entry(1'b0, CMD_PC, '0, pc, '0, pc);
		// only lane 0 at the led address moves the leds
		add_entry(1'b1, 8'h00, 32'h3ff, 32'h0000_0005, 4'b0001, 32'd5);
		add_entry(1'b1, 8'h00, 32'h3ff, 32'h0000_0002, 4'b1110, 32'd5);
		add_entry(1'b1, 8'h00, 32'h3fe, 32'h0000_0003, 4'b1111, 32'd5);
		add_entry(1'b1, 8'h00, 32'h3ff, 32'hffff_fffa, 4'b0001, 32'd2);
	endtask

	// 8N1 frame on i_rx with each bit held CLKS_PER_BIT clocks
	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			i_rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(negedge clk);
		end
	endtask

	// little endian
	task automatic send_word(input word_t w, input int nbytes);
		for (int k = 0; k < nbytes; k++) begin
			send_byte(w[8*k +: 8]);
		end
	endtask

	task automatic line_gap(input int nbits);
		repeat (nbits * CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic get_reply(output word_t w, output logic got_all);
		int waited;
		waited = 0;
		while (rx_q.size() < 4 && waited < REPLY_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		got_all = (rx_q.size() >= 4);
		w = '0;
		if (got_all) begin
			for (int k = 0; k < 4; k++) begin
				w[8*k +: 8] = rx_q.pop_front();
			end
		end
	endtask

	task automatic apply_entry(input int idx);
		entry_t e;
		word_t got;
		logic got_all;
		logic ok;
		int sc;
		int qc;
		e = tbl[idx];
		ok = 1'b1;
		@(negedge clk);
		if (e.is_store) begin
			// one cycle store strobe from the CPU model
			i_st_io.adr = e.adr[RAM_AW-1:0];
			i_st_io.we = e.be;
			i_st_io.data = e.data;
			@(negedge clk);
			i_st_io.we = '0;
			if (o_rgb_led !== e.exp[2:0]) begin
				$display("ERR %0t: entry %0d leds expected %b got %b",
					$time, idx, e.exp[2:0], o_rgb_led);
				ok = 1'b0;
			end
			$display("entry %0d io store: %s", idx, ok ? "pass" : "fail");
		end else begin
			sc = start_cnt;
			qc = quit_cnt;
			rx_q.delete();
			if (e.cmd == CMD_PC) i_pc_data = e.data;
			send_byte(e.cmd);
			case (e.cmd)
				CMD_IWR, CMD_DWR: begin
					send_word(e.adr, 2);
					send_word(e.data, 4);
					line_gap(1);
					// a write sends nothing back and fires no control strobe
					if (rx_q.size() != 0 || start_cnt != sc || quit_cnt != qc) begin
						$display("ERR %0t: entry %0d write gave %0d reply bytes",
							$time, idx, rx_q.size());
						ok = 1'b0;
					end
				end
				CMD_IRD, CMD_DRD, CMD_PC: begin
					if (e.cmd != CMD_PC) send_word(e.adr, 2);
					get_reply(got, got_all);
					if (!got_all) begin
						$display("entry %0d: the DUT sent no complete reply in time", idx);
						ok = 1'b0;
					end else if (got !== e.exp) begin
						$display("ERR %0t: entry %0d reply expected %h got %h",
							$time, idx, e.exp, got);
						ok = 1'b0;
					end
					line_gap(2);
				end
				CMD_GO: begin
					send_word(e.adr, 4);
					line_gap(1);
					if (start_cnt - sc != 1) begin
						$display("ERR %0t: entry %0d start pulses expected 1 got %0d",
							$time, idx, start_cnt - sc);
						ok = 1'b0;
					end
					if (o_start_adr !== e.exp[29:0]) begin
						$display("ERR %0t: entry %0d start address expected %h got %h",
							$time, idx, e.exp[29:0], o_start_adr);
						ok = 1'b0;
					end
				end
				CMD_QUIT: begin
					line_gap(1);
					if (quit_cnt - qc != 1 || start_cnt != sc) begin
						$display("ERR %0t: entry %0d quit pulses expected 1 got %0d",
							$time, idx, quit_cnt - qc);
						ok = 1'b0;
					end
				end
				default: begin
					// a dropped command leaves the line quiet
					line_gap(12);
					if (rx_q.size() != 0 || start_cnt != sc || quit_cnt != qc) begin
						$display("ERR %0t: entry %0d unknown command gave %0d bytes",
							$time, idx, rx_q.size());
						ok = 1'b0;
					end
				end
			endcase
			$display("entry %0d cmd '%c': %s", idx, e.cmd, ok ? "pass" : "fail");
		end
		if (ok) passed++;
		else failed++;
	endtask

	initial begin : main
		i_rx = 1'b1;
		i_arst_n = 1'b0;
		i_pc_data = '0;
		i_st_io = '0;
		seed = 32'h9ba0;
		build_table();
		repeat (10) @(negedge clk);
		i_arst_n = 1'b1;
		@(negedge clk);
		if (o_rgb_led !== 3'b000 || o_tx !== 1'b1 || o_start_adr !== '0
				|| o_cpu_start !== 1'b0 || o_quit_cmd !== 1'b0) begin
			$display("ERR %0t: reset values leds %b tx %b start adr %h",
				$time, o_rgb_led, o_tx, o_start_adr);
			failed++;
			$display("reset values: fail");
		end else begin
			passed++;
			$display("reset values: pass");
		end
		for (int i = 0; i < n_entries; i++) begin
			apply_entry(i);
		end
		$display("tests %0d, passed %0d, failed %0d, line errors %0d",
			n_entries + 1, passed, failed, line_errs);
		if (failed == 0 && line_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
src/rvmon_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/monitor_cmd.sv
src/word_ram.sv
src/io_led.sv
src/fpga_top.sv
dv/fpga_top_assertions.sv
dv/tb_fpga_top.sv

// File: src/fpga_top.sv
/*
 * fpga top, debug monitor side of the RV32I system
 * uart link, command monitor, instruction and data RAMs, led register
 * cpu core sits outside, its control and store port are top ports
 */

`timescale 1ns/1ns
`default_nettype none

module fpga_top
	import rvmon_pkg::*;
(
	input logic clk,
	input logic i_arst_n,
	input logic i_rx,
	output logic o_tx,
	output logic [2:0] o_rgb_led,
	output logic o_cpu_start,
	output start_adr_t o_start_adr,
	output logic o_quit_cmd,
	input word_t i_pc_data,
	input io_store_t i_st_io
);

	// uart to monitor
	byte_t rx_byte;
	logic rx_valid;
	byte_t tx_byte;
	logic tx_send;
	logic tx_busy;

	// monitor to rams
	wadr_t ram_adr;
	word_t ram_wdata;
	logic i_wen;
	logic d_wen;
	word_t i_rdata;
	word_t d_rdata;

	uart_rx u_uart_rx (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_rx(i_rx),
		.o_byte(rx_byte),
		.o_valid(rx_valid)
	);

	uart_tx u_uart_tx (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_send(tx_send),
		.i_byte(tx_byte),
		.o_tx(o_tx),
		.o_busy(tx_busy)
	);

	monitor_cmd u_monitor_cmd (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_rx_byte(rx_byte),
		.i_rx_valid(rx_valid),
		.o_tx_byte(tx_byte),
		.o_tx_send(tx_send),
		.i_tx_busy(tx_busy),
		.o_ram_adr(ram_adr),
		.o_ram_wdata(ram_wdata),
		.o_i_wen(i_wen),
		.o_d_wen(d_wen),
		.i_i_rdata(i_rdata),
		.i_d_rdata(d_rdata),
		.i_pc_data(i_pc_data),
		.o_cpu_start(o_cpu_start),
		.o_quit_cmd(o_quit_cmd),
		.o_start_adr(o_start_adr)
	);

	// instruction ram
	word_ram u_iram (
		.clk(clk),
		.i_adr(ram_adr),
		.i_wdata(ram_wdata),
		.i_wen(i_wen),
		.o_rdata(i_rdata)
	);

	// data ram
	word_ram u_dram (
		.clk(clk),
		.i_adr(ram_adr),
		.i_wdata(ram_wdata),
		.i_wen(d_wen),
		.o_rdata(d_rdata)
	);

	io_led u_io_led (
		.clk(clk),
		.i_arst_n(i_arst_n),
		.i_st(i_st_io),
		.o_rgb_led(o_rgb_led)
	);

endmodule

`default_nettype wire

// File: src/io_led.sv
/*
 * memory-mapped RGB LED register
 * catches CPU stores to IO_LED_ADR on byte lane 0
 */

`timescale 1ns/1ns
`default_nettype none

module io_led
	import rvmon_pkg::*;
(
	input logic clk,
	input logic i_arst_n,
	input io_store_t i_st,
	output logic [2:0] o_rgb_led
);

	logic hit;

	// address match and lowest byte lane written
	assign hit = (i_st.adr == IO_LED_ADR) && i_st.we[0];

	// other lanes or addresses leave the leds alone
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_rgb_led <= '0;
		end else if (hit) begin
			o_rgb_led <= i_st.data[2:0];
		end
	end

endmodule

`default_nettype wire

// File: src/monitor_cmd.sv
/*
 * debug monitor command parser
 * decodes host bytes into RAM writes and reads, cpu start and stop,
 * and returns read data or the pc as four bytes, lsb first
 */

`timescale 1ns/1ns
`default_nettype none

module monitor_cmd
	import rvmon_pkg::*;
(
	input logic clk,
	input logic i_arst_n,
	// uart side
	input byte_t i_rx_byte,
	input logic i_rx_valid,
	output byte_t o_tx_byte,
	output logic o_tx_send,
	input logic i_tx_busy,
	// ram side
	output wadr_t o_ram_adr,
	output word_t o_ram_wdata,
	output logic o_i_wen,
	output logic o_d_wen,
	input word_t i_i_rdata,
	input word_t i_d_rdata,
	// cpu control
	input word_t i_pc_data,
	output logic o_cpu_start,
	output logic o_quit_cmd,
	output start_adr_t o_start_adr
);

	mon_state_e state;
	byte_t cmd;
	logic [1:0] byte_cnt;
	word_t rx_word;
	word_t reply;
	word_t tx_sr;
	logic send_now;

	// incoming bytes enter from the top, little endian
	assign rx_word = {i_rx_byte, o_ram_wdata[31:8]};
	assign send_now = (state == SEND) && !i_tx_busy;

	// first reply byte comes from the source, the rest from the shifter
	always_comb begin
		if (byte_cnt != 2'd0) begin
			reply = tx_sr;
		end else if (cmd == CMD_IRD) begin
			reply = i_i_rdata;
		end else if (cmd == CMD_DRD) begin
			reply = i_d_rdata;
		end else begin
			reply = i_pc_data;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
			cmd <= '0;
			byte_cnt <= '0;
			o_i_wen <= 1'b0;
			o_d_wen <= 1'b0;
			o_cpu_start <= 1'b0;
			o_quit_cmd <= 1'b0;
			o_start_adr <= '0;
			o_tx_send <= 1'b0;
		end else begin
			// strobes last one cycle
			o_i_wen <= 1'b0;
			o_d_wen <= 1'b0;
			o_cpu_start <= 1'b0;
			o_quit_cmd <= 1'b0;
			o_tx_send <= 1'b0;
			case (state)
				IDLE: begin
					if (i_rx_valid) begin
						cmd <= i_rx_byte;
						byte_cnt <= '0;
						case (i_rx_byte)
							CMD_IWR, CMD_DWR, CMD_IRD, CMD_DRD: state <= ADR;
							// go takes a full 32 bit byte address
							CMD_GO: state <= DATA;
							CMD_QUIT: o_quit_cmd <= 1'b1;
							CMD_PC: state <= SEND;
							// unknown command, drop it
							default: state <= IDLE;
						endcase
					end
				end
				ADR: begin
					// two address bytes
					if (i_rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd1) begin
							byte_cnt <= '0;
							state <= (cmd == CMD_IRD || cmd == CMD_DRD) ? READ : DATA;
						end
					end
				end
				DATA: begin
					// four data bytes, counter wraps back to 0
					if (i_rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3) begin
							if (cmd == CMD_GO) begin
								o_start_adr <= rx_word[31:2];
								o_cpu_start <= 1'b1;
								state <= IDLE;
							end else begin
								o_i_wen <= (cmd == CMD_IWR);
								o_d_wen <= (cmd == CMD_DWR);
								state <= WRITE;
							end
						end
					end
				end
				// wen is high in this cycle
				WRITE: state <= IDLE;
				// address on the ram, data next cycle
				READ: state <= SEND;
				SEND: begin
					if (!i_tx_busy) begin
						o_tx_send <= 1'b1;
						byte_cnt <= byte_cnt + 1'b1;
						state <= WAIT_TX;
					end
				end
				WAIT_TX: begin
					// busy only rises the cycle after the send strobe
					if (!o_tx_send && !i_tx_busy) begin
						state <= (byte_cnt == 2'd0) ? IDLE : SEND;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (i_rx_valid && (state == ADR || state == DATA)) begin
			o_ram_wdata <= rx_word;
		end
		// high address bits are ignored
		if (i_rx_valid && state == ADR && byte_cnt == 2'd1) begin
			o_ram_adr <= rx_word[16 +: RAM_AW];
		end
		if (send_now) begin
			o_tx_byte <= reply[7:0];
			tx_sr <= {8'h00, reply[31:8]};
		end
	end

endmodule

`default_nettype wire

// File: src/rvmon_pkg.sv
/*
 * rvmon package
 * shared widths, vector types, host command codes, monitor FSM states
 * and the CPU I/O store bundle for the RV32I debug monitor
 */

`default_nettype none

package rvmon_pkg;

	// uart timing, clock cycles per serial bit
	localparam int CLKS_PER_BIT = 16;

	// word address width of both RAMs
	localparam int RAM_AW = 10;

	// plain vector types
	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [RAM_AW-1:0] wadr_t;
	typedef logic [29:0] start_adr_t;
	typedef logic [3:0] be_t;
	// counts clocks inside one uart bit
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] bitcnt_t;

	// led register sits at the top word of the I/O space
	localparam wadr_t IO_LED_ADR = '1;

	// host commands, ascii
	localparam byte_t CMD_IWR = 8'h77;  // "w"
	localparam byte_t CMD_DWR = 8'h78;  // "x"
	localparam byte_t CMD_IRD = 8'h72;  // "r"
	localparam byte_t CMD_DRD = 8'h73;  // "s"
	localparam byte_t CMD_GO = 8'h67;   // "g"
	localparam byte_t CMD_QUIT = 8'h71; // "q"
	localparam byte_t CMD_PC = 8'h70;   // "p"

	// monitor command FSM
	typedef enum logic [2:0] {
		IDLE,
		ADR,
		DATA,
		WRITE,
		READ,
		SEND,
		WAIT_TX
	} mon_state_e;

	// one CPU store into I/O space
	typedef struct packed {
		wadr_t adr;
		be_t we;
		word_t data;
	} io_store_t;

endpackage

`default_nettype wire

// File: src/uart_rx.sv
/*
 * uart receiver, 8N1
 * samples each bit in the middle and pulses o_valid for a good stop bit
 */

`timescale 1ns/1ns
`default_nettype none

module uart_rx
	import rvmon_pkg::*;
(
	input logic clk,
	input logic i_arst_n,
	input logic i_rx,
	output byte_t o_byte,
	output logic o_valid
);

	logic rx_meta;
	logic rx_sync;
	logic active;
	bitcnt_t clk_cnt;
	logic [3:0] bit_idx;
	logic sample;

	// two flop synchronizer, line idles high
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	// mid-bit sample point
	assign sample = active && (clk_cnt == '0);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			active <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			if (!active) begin
				// start bit edge, wait half a bit to hit its middle
				if (!rx_sync) begin
					active <= 1'b1;
					clk_cnt <= bitcnt_t'(CLKS_PER_BIT / 2 - 1);
					bit_idx <= '0;
				end
			end else if (!sample) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= bitcnt_t'(CLKS_PER_BIT - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0 && rx_sync) begin
					// start bit gone high again, just a glitch
					active <= 1'b0;
				end else if (bit_idx == 4'd9) begin
					// stop bit, framing error drops the byte
					active <= 1'b0;
					o_valid <= rx_sync;
				end
			end
		end
	end

	// data bits 1..8 shift in lsb first
	always_ff @(posedge clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
			o_byte <= {rx_sync, o_byte[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
/*
 * uart transmitter, 8N1
 * i_send loads a frame, o_busy covers all ten bits
 */

`timescale 1ns/1ns
`default_nettype none

module uart_tx
	import rvmon_pkg::*;
(
	input logic clk,
	input logic i_arst_n,
	input logic i_send,
	input byte_t i_byte,
	output logic o_tx,
	output logic o_busy
);

	logic [9:0] frame;
	bitcnt_t clk_cnt;
	logic [3:0] bit_idx;
	logic start;
	logic bit_end;

	assign start = i_send && !o_busy;
	assign bit_end = o_busy && (clk_cnt == '0);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (start) begin
			o_busy <= 1'b1;
			clk_cnt <= bitcnt_t'(CLKS_PER_BIT - 1);
			bit_idx <= '0;
		end else if (o_busy) begin
			if (!bit_end) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= bitcnt_t'(CLKS_PER_BIT - 1);
				bit_idx <= bit_idx + 1'b1;
				// stop bit done
				if (bit_idx == 4'd9) begin
					o_busy <= 1'b0;
				end
			end
		end
	end

	// stop, data lsb first, start
	always_ff @(posedge clk) begin
		if (start) begin
			frame <= {1'b1, i_byte, 1'b0};
		end else if (bit_end) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	// idle line high
	assign o_tx = o_busy ? frame[0] : 1'b1;

endmodule

`default_nettype wire

// File: src/word_ram.sv
/*
 * 1024 x 32 word RAM
 * synchronous write, registered read, maps onto a block RAM
 */

`timescale 1ns/1ns
`default_nettype none

module word_ram
	import rvmon_pkg::*;
(
	input logic clk,
	input wadr_t i_adr,
	input word_t i_wdata,
	input logic i_wen,
	output word_t o_rdata
);

	word_t mem [2**RAM_AW];

	// read is old data on a same-address write
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_adr] <= i_wdata;
		end
		o_rdata <= mem[i_adr];
	end

endmodule

`default_nettype wire
